/* hdl/mini_cpu_pkg.sv */
package mini_cpu_pkg;

	localparam int INST_ADDR_W = 8;  // 256 instruction words.
	localparam int DATA_ADDR_W = 8;
	localparam int CLKS_PER_BIT = 8;
	localparam int BAUD_CNT_W = $clog2(CLKS_PER_BIT);

	// opcode values follow the MIPS encodings, with IN and OUT in unused slots.
	localparam logic [5:0] OP_ADDI = 6'b001000;
	localparam logic [5:0] OP_J    = 6'b000010;
	localparam logic [5:0] OP_LW   = 6'b100011;
	localparam logic [5:0] OP_SW   = 6'b101011;
	localparam logic [5:0] OP_IN   = 6'b011010;
	localparam logic [5:0] OP_OUT  = 6'b011011;

	typedef enum logic {
		MODE_LOAD = 1'b0,
		MODE_EXEC = 1'b1
	} cpu_mode_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;   // base register.
		logic [4:0]  rt;   // target register.
		logic [15:0] imm;  // the J target sits in the low INST_ADDR_W bits.
	} instr_t;

	typedef struct packed {
		logic [DATA_ADDR_W-1:0] addr;
		logic [31:0]            wdata;
		logic                   we;
	} ram_req_t;

endpackage

/* hdl/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx import mini_cpu_pkg::*; (
	input  logic       CLK,
	input  logic       arst_n,
	input  logic       rx,
	output logic [7:0] rx_data,
	output logic       rx_valid
);

	logic [1:0]            rx_sync;
	logic                  rx_prev;
	logic                  busy;
	logic [3:0]            bit_idx;  // 0 is the start bit, 9 the stop bit.
	logic [BAUD_CNT_W-1:0] clk_cnt;
	logic [7:0]            shift;
	logic                  sample;

	assign sample = busy && clk_cnt == '0;
	assign rx_data = shift;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			rx_sync  <= 2'b11;
			rx_prev  <= 1'b1;
			busy     <= 1'b0;
			bit_idx  <= '0;
			clk_cnt  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			rx_sync  <= {rx_sync[0], rx};
			rx_prev  <= rx_sync[1];
			if (!busy) begin
				if (rx_prev && !rx_sync[1]) begin
					busy    <= 1'b1;
					bit_idx <= '0;
					clk_cnt <= BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1);  // aim at mid start bit.
				end
			end else if (clk_cnt != '0) begin
				clk_cnt <= clk_cnt - 1'b1;
			end else begin
				clk_cnt <= BAUD_CNT_W'(CLKS_PER_BIT - 1);
				bit_idx <= bit_idx + 1'b1;
				if (bit_idx == 4'd0 && rx_sync[1])
					busy <= 1'b0;  // glitch, not a real start bit.
				if (bit_idx == 4'd9) begin
					busy     <= 1'b0;
					rx_valid <= rx_sync[1];  // a bad stop bit drops the byte.
				end
			end
		end
	end

	// data bits arrive LSB first and shift down into place.
	always_ff @(posedge CLK) begin
		if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8)
			shift <= {rx_sync[1], shift[7:1]};
	end

endmodule

/* hdl/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx import mini_cpu_pkg::*; (
	input  logic       CLK,
	input  logic       arst_n,
	input  logic [7:0] tx_data,
	input  logic       tx_send,
	output logic       tx,
	output logic       tx_ready
);

	logic [9:0]            frame;
	logic [3:0]            bit_cnt;
	logic [BAUD_CNT_W-1:0] clk_cnt;
	logic                  busy;

	assign tx = frame[0];
	assign tx_ready = !busy;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			frame   <= '1;  // line idles high.
			bit_cnt <= '0;
			clk_cnt <= '0;
			busy    <= 1'b0;
		end else if (!busy) begin
			if (tx_send) begin
				frame   <= {1'b1, tx_data, 1'b0};
				bit_cnt <= '0;
				clk_cnt <= BAUD_CNT_W'(CLKS_PER_BIT - 1);
				busy    <= 1'b1;
			end
		end else if (clk_cnt != '0) begin
			clk_cnt <= clk_cnt - 1'b1;
		end else begin
			frame   <= {1'b1, frame[9:1]};
			clk_cnt <= BAUD_CNT_W'(CLKS_PER_BIT - 1);
			if (bit_cnt == 4'd9)
				busy <= 1'b0;  // end of the stop bit.
			else
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

endmodule

/* hdl/data_ram.sv */
`timescale 1ns/100ps

module data_ram import mini_cpu_pkg::*; (
	input  logic        CLK,
	input  ram_req_t    req,
	output logic [31:0] rdata
);

	logic [31:0] mem [2**DATA_ADDR_W];

	// read returns the old word when the same address is written.
	always_ff @(posedge CLK) begin
		if (req.we)
			mem[req.addr] <= req.wdata;
		rdata <= mem[req.addr];
	end

endmodule

/* hdl/mini_cpu_core.sv */
`timescale 1ns/100ps

module mini_cpu_core import mini_cpu_pkg::*; (
	input  logic        CLK,
	input  logic        arst_n,
	input  logic        sw_load,
	input  logic        sw_exec,
	input  logic [7:0]  rx_data,
	input  logic        rx_valid,
	input  logic        tx_ready,
	input  logic [31:0] ram_rdata,
	output logic [7:0]  tx_data,
	output logic        tx_send,
	output ram_req_t    ram_req,
	output logic        led_load,
	output logic        led_exec,
	output logic [5:0]  led_debug
);

	cpu_mode_t              mode;
	logic [INST_ADDR_W-1:0] pc;
	logic [1:0]             byte_cnt;  // byte lane of the word being loaded.
	logic [31:0]            imem [2**INST_ADDR_W];
	logic [31:0][31:0]      gpr;
	logic                   lw_phase;

	instr_t      instr;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic [31:0] imm_sext;
	logic        switching;
	logic        load_wr;
	logic        exec_go;
	logic        stall;

	assign instr = instr_t'(imem[pc]);
	assign rs_val = gpr[instr.rs];
	assign rt_val = gpr[instr.rt];
	assign imm_sext = {{16{instr.imm[15]}}, instr.imm};

	// a switch press overrides whatever the current mode would do this cycle.
	assign switching = sw_load || sw_exec;
	assign load_wr = mode == MODE_LOAD && rx_valid && !switching;
	assign exec_go = mode == MODE_EXEC && !switching;

	// IN waits for a byte, OUT for the transmitter, LW for its second cycle.
	assign stall = (instr.op == OP_IN && !rx_valid) ||
		(instr.op == OP_OUT && !tx_ready) ||
		(instr.op == OP_LW && !lw_phase);

	assign ram_req.addr = rs_val[DATA_ADDR_W-1:0] + imm_sext[DATA_ADDR_W-1:0];
	assign ram_req.wdata = rt_val;
	assign ram_req.we = exec_go && instr.op == OP_SW;

	assign tx_data = rt_val[7:0];
	assign tx_send = exec_go && instr.op == OP_OUT && tx_ready;

	assign led_load = mode == MODE_LOAD;
	assign led_exec = mode == MODE_EXEC;
	assign led_debug = {pc[3:0], byte_cnt};

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			mode     <= MODE_LOAD;
			pc       <= '0;
			byte_cnt <= '0;
		end else if (sw_load) begin  // load has priority over exec.
			mode     <= MODE_LOAD;
			pc       <= '0;
			byte_cnt <= '0;
		end else if (sw_exec) begin
			mode <= MODE_EXEC;
			pc   <= '0;
		end else if (mode == MODE_LOAD) begin
			if (rx_valid)
				{pc, byte_cnt} <= {pc, byte_cnt} + 1'b1;
		end else if (instr.op == OP_J) begin
			pc <= instr.imm[INST_ADDR_W-1:0];
		end else if (!stall) begin
			pc <= pc + 1'b1;
		end
	end

	// byte 0 of each word is the least significant one.
	always_ff @(posedge CLK) begin
		if (load_wr)
			imem[pc][{byte_cnt, 3'b000} +: 8] <= rx_data;
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			gpr      <= '0;
			lw_phase <= 1'b0;
		end else begin
			lw_phase <= exec_go && instr.op == OP_LW && !lw_phase;
			if (exec_go) begin
				case (instr.op)
					OP_ADDI: gpr[instr.rt] <= rs_val + imm_sext;
					OP_LW: begin
						if (lw_phase)
							gpr[instr.rt] <= ram_rdata;  // RAM read landed this cycle.
					end
					OP_IN: begin
						if (rx_valid)
							gpr[instr.rt] <= {24'd0, rx_data};
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* hdl/mini_cpu_top.sv */
`timescale 1ns/100ps

module mini_cpu_top import mini_cpu_pkg::*; (
	input  logic       CLK,
	input  logic       arst_n,
	input  logic       rx,
	input  logic       sw_load,
	input  logic       sw_exec,
	output logic       tx,
	output logic       led_load,
	output logic       led_exec,
	output logic [5:0] led_debug
);

	logic [7:0]  rx_data;
	logic        rx_valid;
	logic [7:0]  tx_data;
	logic        tx_send;
	logic        tx_ready;
	ram_req_t    ram_req;
	logic [31:0] ram_rdata;

	uart_rx i_uart_rx (
		.CLK      (CLK),
		.arst_n   (arst_n),
		.rx       (rx),
		.rx_data  (rx_data),
		.rx_valid (rx_valid)
	);

	uart_tx i_uart_tx (
		.CLK      (CLK),
		.arst_n   (arst_n),
		.tx_data  (tx_data),
		.tx_send  (tx_send),
		.tx       (tx),
		.tx_ready (tx_ready)
	);

	data_ram i_data_ram (
		.CLK   (CLK),
		.req   (ram_req),
		.rdata (ram_rdata)
	);

	mini_cpu_core i_mini_cpu_core (
		.CLK       (CLK),
		.arst_n    (arst_n),
		.sw_load   (sw_load),
		.sw_exec   (sw_exec),
		.rx_data   (rx_data),
		.rx_valid  (rx_valid),
		.tx_ready  (tx_ready),
		.ram_rdata (ram_rdata),
		.tx_data   (tx_data),
		.tx_send   (tx_send),
		.ram_req   (ram_req),
		.led_load  (led_load),
		.led_exec  (led_exec),
		.led_debug (led_debug)
	);

endmodule

/* verif/mini_cpu_tb_assert.sv */
`timescale 1ns/100ps

module mini_cpu_tb_assert import mini_cpu_pkg::*; (
	input logic      CLK,
	input logic      arst_n,
	input cpu_mode_t mode,
	input logic      tx_send,
	input ram_req_t  ram_req,
	input logic      lw_phase
);

	int fail_cnt;  // number of failed assertions so far.

	initial fail_cnt = 0;

	// only an OUT in execute mode may start the transmitter.
	no_send_in_load: assert property (@(posedge CLK) disable iff (!arst_n)
		mode == MODE_LOAD |-> !tx_send)
	else begin
		fail_cnt = fail_cnt + 1;
		$error("tx_send is high while the core is in load mode.");
	end

	no_write_in_load: assert property (@(posedge CLK) disable iff (!arst_n)
		mode == MODE_LOAD |-> !ram_req.we)
	else begin
		fail_cnt = fail_cnt + 1;
		$error("data RAM write enable is high while the core is in load mode.");
	end

	// a load is two cycles, never three.
	lw_phase_single: assert property (@(posedge CLK) disable iff (!arst_n)
		lw_phase |=> !lw_phase)
	else begin
		fail_cnt = fail_cnt + 1;
		$error("lw_phase stayed high for two cycles in a row.");
	end

endmodule

bind mini_cpu_core mini_cpu_tb_assert i_mini_cpu_tb_assert (
	.CLK      (CLK),
	.arst_n   (arst_n),
	.mode     (mode),
	.tx_send  (tx_send),
	.ram_req  (ram_req),
	.lw_phase (lw_phase)
);

/* verif/mini_cpu_tb.sv */
`timescale 1ns/100ps

module mini_cpu_tb import mini_cpu_pkg::*; ();

	localparam logic [31:0] SEED = 32'h75b7a625;
	// about 115 frames of 11 bit times each, with roughly twice that as margin.
	localparam int MAX_CYCLES = 20000;

	logic       CLK;
	logic       arst_n;
	logic       rx;
	logic       sw_load;
	logic       sw_exec;
	logic       tx;
	logic       led_load;
	logic       led_exec;
	logic [5:0] led_debug;

	string       test_name;
	int          cycles;
	logic [31:0] prog_q[$];

	mini_cpu_top i_mini_cpu_top (
		.CLK       (CLK),
		.arst_n    (arst_n),
		.rx        (rx),
		.sw_load   (sw_load),
		.sw_exec   (sw_exec),
		.tx        (tx),
		.led_load  (led_load),
		.led_exec  (led_exec),
		.led_debug (led_debug)
	);

	initial CLK = 1'b0;
	always #2 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: test %s did not finish within %0d cycles.", test_name, MAX_CYCLES);
			$display("Regression failed");
			$fatal(1, "timeout");
		end
	end

	always @(negedge CLK) begin
		if (i_mini_cpu_top.i_mini_cpu_core.i_mini_cpu_tb_assert.fail_cnt != 0) begin
			$display("An assertion on the core failed during test %s.", test_name);
			$display("Regression failed");
			$fatal(1, "assertion failure");
		end
	end

	task automatic check_byte(input logic [7:0] expected, input logic [7:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected 8'h%02h, actual 8'h%02h", test_name, expected, actual);
			$display("Regression failed");
			$fatal(1, "byte mismatch");
		end
	endtask

	task automatic check_mode(input cpu_mode_t expected, input cpu_mode_t actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %s, actual %s", test_name, expected.name(),
				actual.name());
			$display("Regression failed");
			$fatal(1, "mode mismatch");
		end
	endtask

	task automatic check_debug(input logic [5:0] expected, input logic [5:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected 6'b%06b, actual 6'b%06b", test_name, expected, actual);
			$display("Regression failed");
			$fatal(1, "debug mismatch");
		end
	endtask

	task automatic check_level(input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected level %b, actual level %b", test_name, expected, actual);
			$display("Regression failed");
			$fatal(1, "level mismatch");
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge CLK);
	endtask

	function automatic logic [7:0] rand_byte();
		return 8'($urandom);
	endfunction

	function automatic logic [31:0] make_instr(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		instr_t instr;
		instr.op = op;
		instr.rs = rs;
		instr.rt = rt;
		instr.imm = imm;
		return instr;
	endfunction

	// start bit, eight data bits LSB first, stop bit, then one idle bit.
	task automatic send_byte(input logic [7:0] data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rx = frame[i];
			wait_cycles(CLKS_PER_BIT);
		end
		wait_cycles(CLKS_PER_BIT);
	endtask

	task automatic recv_byte(output logic [7:0] data);
		while (tx !== 1'b0)
			@(negedge CLK);
		wait_cycles(CLKS_PER_BIT / 2);  // middle of the start bit.
		for (int i = 0; i < 8; i++) begin
			wait_cycles(CLKS_PER_BIT);
			data[i] = tx;
		end
		wait_cycles(CLKS_PER_BIT);
		check_level(1'b1, tx);  // stop bit.
	endtask

	// the reply can start before the sent frame has finished.
	task automatic exchange(input logic [7:0] data, output logic [7:0] reply);
		logic [7:0] got;
		fork
			send_byte(data);
			recv_byte(got);
		join
		reply = got;
	endtask

	task automatic pulse_load();
		sw_load = 1'b1;
		wait_cycles(1);
		sw_load = 1'b0;
	endtask

	task automatic pulse_exec();
		sw_exec = 1'b1;
		wait_cycles(1);
		sw_exec = 1'b0;
	endtask

	task automatic load_program();
		logic [31:0] word;
		pulse_load();
		foreach (prog_q[i]) begin
			word = prog_q[i];
			for (int b = 0; b < 4; b++)
				send_byte(word[8*b +: 8]);
		end
		pulse_exec();
	endtask

	task automatic expect_mode(input cpu_mode_t expected);
		check_mode(expected, cpu_mode_t'(led_exec));
		check_level(expected == MODE_LOAD, led_load);
	endtask

	task automatic fill_echo();
		prog_q.delete();
		prog_q.push_back(make_instr(OP_IN, 5'd0, 5'd1, 16'd0));
		prog_q.push_back(make_instr(OP_OUT, 5'd0, 5'd1, 16'd0));
		prog_q.push_back(make_instr(OP_J, 5'd0, 5'd0, 16'd0));
	endtask

	task automatic fill_addi(input int imm);
		prog_q.delete();
		prog_q.push_back(make_instr(OP_IN, 5'd0, 5'd1, 16'd0));
		prog_q.push_back(make_instr(OP_ADDI, 5'd1, 5'd2, 16'(imm)));
		prog_q.push_back(make_instr(OP_OUT, 5'd0, 5'd2, 16'd0));
		prog_q.push_back(make_instr(OP_J, 5'd0, 5'd0, 16'd0));
	endtask

	task automatic run_echo(input int n);
		logic [7:0] data;
		logic [7:0] got;
		repeat (n) begin
			data = rand_byte();
			exchange(data, got);
			check_byte(data, got);
		end
	endtask

	task automatic test_reset_load();
		test_name = "reset_load";
		expect_mode(MODE_LOAD);
		check_debug(6'd0, led_debug);
		check_level(1'b1, tx);
		repeat (5) send_byte(rand_byte());
		check_debug({4'd1, 2'd1}, led_debug);  // five bytes are one word and one byte.
	endtask

	task automatic test_echo();
		test_name = "echo";
		fill_echo();
		load_program();
		expect_mode(MODE_EXEC);
		run_echo(4);
	endtask

	task automatic test_addi(input int imm);
		logic [7:0] data;
		logic [7:0] got;
		test_name = $sformatf("addi_%0d", imm);
		fill_addi(imm);
		load_program();
		repeat (2) begin
			data = rand_byte();
			exchange(data, got);
			check_byte(8'(data + imm), got);
		end
	endtask

	task automatic test_data_mem();
		logic [7:0] data;
		logic [7:0] got;
		test_name = "data_mem";
		prog_q.delete();
		prog_q.push_back(make_instr(OP_IN, 5'd0, 5'd1, 16'd0));
		prog_q.push_back(make_instr(OP_SW, 5'd0, 5'd1, 16'd16));
		prog_q.push_back(make_instr(OP_ADDI, 5'd1, 5'd1, 16'd1));
		prog_q.push_back(make_instr(OP_LW, 5'd0, 5'd3, 16'd16));
		prog_q.push_back(make_instr(OP_OUT, 5'd0, 5'd3, 16'd0));
		prog_q.push_back(make_instr(OP_J, 5'd0, 5'd0, 16'd0));
		load_program();
		repeat (2) begin
			data = rand_byte();
			exchange(data, got);
			check_byte(data, got);
		end
	endtask

	task automatic test_mode_switch();
		logic [7:0] data;
		logic [7:0] got;
		test_name = "mode_switch";
		prog_q.delete();
		prog_q.push_back(make_instr(OP_J, 5'd0, 5'd0, 16'd1));  // the loop starts at word 1.
		prog_q.push_back(make_instr(OP_IN, 5'd0, 5'd1, 16'd0));
		prog_q.push_back(make_instr(OP_ADDI, 5'd1, 5'd2, 16'd7));
		prog_q.push_back(make_instr(OP_OUT, 5'd0, 5'd2, 16'd0));
		prog_q.push_back(make_instr(OP_J, 5'd0, 5'd0, 16'd1));
		load_program();
		data = rand_byte();
		exchange(data, got);
		check_byte(8'(data + 7), got);
		wait_cycles(CLKS_PER_BIT);  // the core sits on IN again.
		check_debug({4'd1, 2'd0}, led_debug);
		pulse_load();
		expect_mode(MODE_LOAD);
		check_debug(6'd0, led_debug);
		fill_echo();
		load_program();
		expect_mode(MODE_EXEC);
		run_echo(2);
	endtask

	initial begin
		logic [31:0] seed_ret;
		seed_ret = $urandom(SEED);
		cycles = 0;
		test_name = "reset";
		arst_n = 1'b0;
		rx = 1'b1;
		sw_load = 1'b0;
		sw_exec = 1'b0;
		wait_cycles(2);
		arst_n = 1'b1;
		wait_cycles(1);

		test_reset_load();
		test_echo();
		test_addi(5);
		test_addi(-3);
		test_data_mem();
		test_mode_switch();

		wait_cycles(2);
		if (i_mini_cpu_top.i_mini_cpu_core.i_mini_cpu_tb_assert.fail_cnt == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("Regression failed");
			$fatal(1, "assertion failures were counted");
		end
	end

endmodule

/* src.f */
hdl/mini_cpu_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/data_ram.sv
hdl/mini_cpu_core.sv
hdl/mini_cpu_top.sv
verif/mini_cpu_tb_assert.sv
verif/mini_cpu_tb.sv

/* Makefile */
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
RUN_FLAGS := +verilator+error+limit+10
TOP       := mini_cpu_tb
FILELIST  := src.f
LOG       := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -qx "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
